// File: harden_rx.f
design/rx_pkg.sv
design/rx_ctrl.sv
design/cp_remover.sv
design/sample_compressor.sv
design/rx_lane.sv
design/rx_status.sv
design/harden_rx.sv
verif/harden_rx_tb.sv

// File: Makefile
TOP = harden_rx_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f harden_rx.f --top-module $(TOP)

obj_dir/$(TOP): harden_rx.f design/*.sv verif/*.sv
	verilator --binary --timing --assert -f harden_rx.f --top-module $(TOP) -o $(TOP)

sim: obj_dir/$(TOP)
	./obj_dir/$(TOP) > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "Simulation failed" sim.log; then exit 1; fi
	@grep -q "Simulation passed" sim.log

clean:
	rm -rf obj_dir sim.log

// File: verif/harden_rx_tb.sv
// lane model tracks one symbol per lane; restarts are only issued once both lanes have drained
`timescale 1ns/100ps

module harden_rx_tb;

  localparam int LANES         = 2;
  localparam int FFT_SIZE      = 64;
  localparam int CP_LEN_LONG   = 11;
  localparam int CP_LEN_SHORT  = 9;
  localparam int DRAIN_LIMIT   = 2000;
  localparam int WORDS_PER_SYM = FFT_SIZE / rx_pkg::SAMPLES_PER_WORD;

  logic        link_clk;
  logic        rst_n;
  logic [31:0] gp_control;
  logic [31:0] gp_status_0;
  logic [31:0] gp_status_1;
  logic [31:0] gp_status_2;
  logic        trigger;
  logic        long_cp;
  logic [3:0]  din_symbol;
  logic [7:0]  din_slot;
  logic [9:0]  din_frame;
  logic [15:0] data_in_i [LANES];
  logic [15:0] data_in_q [LANES];
  logic [LANES-1:0] valid_in;
  logic [1:0]  enable_in [LANES];
  logic [63:0] dout_data [LANES];
  logic [LANES-1:0] dout_valid;
  logic [LANES-1:0] dout_sop;
  logic [LANES-1:0] dout_eop;
  logic [3:0]  dout_symbol [LANES];
  logic [7:0]  dout_slot [LANES];
  logic [9:0]  dout_frame [LANES];

  int               seed;
  logic [LANES-1:0] full_scale;
  int               errors;
  int               checks;
  int               tests_run;
  int               tests_failed;
  int               test_err0;
  string            test_name;
  int               tag_seq;
  int               words_seen [LANES];
  int               word_base [LANES];

  // reference model of the lanes
  int               m_rcnt;
  logic             m_trig;
  logic             m_long;
  rx_pkg::sym_tag_t m_tag_in;
  logic             m_act [LANES];
  int               m_skip [LANES];
  int               m_cnt [LANES];
  logic [63:0]      m_data [LANES];
  rx_pkg::sym_tag_t m_tag [LANES];
  rx_pkg::rx_word_t exp_q0 [$];
  rx_pkg::rx_word_t exp_q1 [$];

  harden_rx #(
    .LANES       (LANES),
    .FFT_SIZE    (FFT_SIZE),
    .CP_LEN_LONG (CP_LEN_LONG),
    .CP_LEN_SHORT(CP_LEN_SHORT)
  ) dut0 (
    .link_clk   (link_clk),
    .rst_n      (rst_n),
    .gp_control (gp_control),
    .gp_status_0(gp_status_0),
    .gp_status_1(gp_status_1),
    .gp_status_2(gp_status_2),
    .trigger    (trigger),
    .long_cp    (long_cp),
    .din_symbol (din_symbol),
    .din_slot   (din_slot),
    .din_frame  (din_frame),
    .data_in_i  (data_in_i),
    .data_in_q  (data_in_q),
    .valid_in   (valid_in),
    .enable_in  (enable_in),
    .dout_data  (dout_data),
    .dout_valid (dout_valid),
    .dout_sop   (dout_sop),
    .dout_eop   (dout_eop),
    .dout_symbol(dout_symbol),
    .dout_slot  (dout_slot),
    .dout_frame (dout_frame)
  );

  initial begin
    link_clk = 1'b0;
    forever #20 link_clk = ~link_clk;
  end

  // near full scale: just above the positive rail or right at the negative one
  function automatic logic [15:0] make_sample(input logic fs, input logic [31:0] r);
    if (fs) begin
      return r[7] ? {9'h0ff, r[6:0]} : {9'h100, r[6:0]};
    end
    return {{2{r[15]}}, r[13:0]};
  endfunction

  // msb set when the value had to be limited
  function automatic logic [8:0] round_sat(input logic [15:0] x);
    int v;
    v = (int'($signed(x)) + 128) >>> 8;
    if (v > 127) begin
      return {1'b1, 8'h7f};
    end
    if (v < -128) begin
      return {1'b1, 8'h80};
    end
    return {1'b0, v[7:0]};
  endfunction

  function automatic int expected_left(input int l);
    return (l == 0) ? exp_q0.size() : exp_q1.size();
  endfunction

  function automatic rx_pkg::rx_word_t pop_expected(input int l);
    if (l == 0) begin
      return exp_q0.pop_front();
    end
    return exp_q1.pop_front();
  endfunction

  function automatic logic model_busy();
    return m_trig || m_act[0] || m_act[1] || (exp_q0.size() != 0) || (exp_q1.size() != 0);
  endfunction

  task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] want);
    checks++;
    if (got !== want) begin
      errors++;
      $display("ERROR at %0t ns: %s is %0h, expected %0h", $time, name, got, want);
    end
  endtask

  // model at the rising edge, then new stimulus, then output compare at the falling edge
  always begin : lane_bench
    logic             restart_ok;
    logic [8:0]       re8;
    logic [8:0]       im8;
    logic [31:0]      r;
    rx_pkg::rx_word_t w;
    int               k;
    int               l;
    @(posedge link_clk);
    restart_ok = rst_n && gp_control[rx_pkg::CTRL_ENABLE_BIT];
    for (l = 0; l < LANES; l++) begin
      if (!restart_ok || m_rcnt != rx_pkg::RST_STAGES) begin
        m_act[l] = 1'b0;
      end else if (!m_act[l]) begin
        if (m_trig && (&enable_in[l])) begin
          m_act[l] = 1'b1;
          m_cnt[l] = 0;
          m_tag[l] = m_tag_in;
          if (gp_control[rx_pkg::CTRL_BYPASS_CP_BIT]) begin
            m_skip[l] = 0;
          end else begin
            m_skip[l] = m_long ? CP_LEN_LONG : CP_LEN_SHORT;
          end
        end
      end else if (valid_in[l]) begin
        if (m_skip[l] != 0) begin
          m_skip[l]--;
        end else begin
          re8 = round_sat(data_in_i[l]);
          im8 = round_sat(data_in_q[l]);
          k = m_cnt[l] % rx_pkg::SAMPLES_PER_WORD;
          m_data[l][63 - 16 * k -: 8] = re8[7:0];
          m_data[l][55 - 16 * k -: 8] = im8[7:0];
          m_cnt[l]++;
          if (k == rx_pkg::SAMPLES_PER_WORD - 1) begin
            w = '{data: m_data[l], valid: 1'b1, sop: (m_cnt[l] == rx_pkg::SAMPLES_PER_WORD),
                  eop: (m_cnt[l] == FFT_SIZE), tag: m_tag[l]};
            if (l == 0) begin
              exp_q0.push_back(w);
            end else begin
              exp_q1.push_back(w);
            end
          end
          if (m_cnt[l] == FFT_SIZE) begin
            m_act[l] = 1'b0;
          end
        end
      end
    end
    if (!restart_ok) begin
      m_rcnt = 0;
    end else if (m_rcnt != rx_pkg::RST_STAGES) begin
      m_rcnt++;
    end
    m_trig   = rst_n && trigger;
    m_long   = long_cp;
    m_tag_in = '{symbol: din_symbol, slot: din_slot, frame: din_frame};
    // about three valid samples in four
    for (l = 0; l < LANES; l++) begin
      r = $random(seed);
      valid_in[l]  <= (r[1:0] != 2'b00);
      data_in_i[l] <= make_sample(full_scale[l], $random(seed));
      data_in_q[l] <= make_sample(full_scale[l], $random(seed));
    end
    @(negedge link_clk);
    for (l = 0; l < LANES; l++) begin
      if (rst_n === 1'b1 && dout_valid[l] === 1'b1) begin
        if (expected_left(l) == 0) begin
          errors++;
          $display("lane %0d delivered a word that no accepted trigger explains at %0t ns",
                   l, $time);
        end else begin
          w = pop_expected(l);
          words_seen[l]++;
          check_value($sformatf("dout_data[%0d]", l), dout_data[l], w.data);
          check_value($sformatf("dout_sop[%0d]", l), 64'(dout_sop[l]), 64'(w.sop));
          check_value($sformatf("dout_eop[%0d]", l), 64'(dout_eop[l]), 64'(w.eop));
          check_value($sformatf("dout_symbol[%0d]", l), 64'(dout_symbol[l]), 64'(w.tag.symbol));
          check_value($sformatf("dout_slot[%0d]", l), 64'(dout_slot[l]), 64'(w.tag.slot));
          check_value($sformatf("dout_frame[%0d]", l), 64'(dout_frame[l]), 64'(w.tag.frame));
        end
      end
    end
  end

  // called on a rising edge, returns on the next one
  task automatic send_trigger(input logic long_sel);
    tag_seq++;
    trigger    <= 1'b1;
    long_cp    <= long_sel;
    din_symbol <= 4'(tag_seq);
    din_slot   <= 8'(tag_seq * 13);
    din_frame  <= 10'(tag_seq * 37 + 5);
    @(posedge link_clk);
    trigger <= 1'b0;
  endtask

  task automatic wait_drained(input string what);
    int n;
    n = 0;
    @(negedge link_clk);
    while (model_busy() && n < DRAIN_LIMIT) begin
      @(negedge link_clk);
      n++;
    end
    if (model_busy()) begin
      errors++;
      $display("timeout: %s did not complete within %0d cycles", what, DRAIN_LIMIT);
    end
    @(posedge link_clk);
  endtask

  task automatic wait_restart();
    int n;
    n = 0;
    @(negedge link_clk);
    while (m_rcnt != rx_pkg::RST_STAGES && n < 100) begin
      @(negedge link_clk);
      n++;
    end
    if (m_rcnt != rx_pkg::RST_STAGES) begin
      errors++;
      $display("timeout: the lane reset was never released");
    end
    @(posedge link_clk);
  endtask

  task automatic check_status(input int cnt0, input int cnt1, input logic [31:0] flags);
    @(negedge link_clk);
    check_value("gp_status_0", 64'(gp_status_0), 64'(cnt0));
    check_value("gp_status_1", 64'(gp_status_1), 64'(cnt1));
    check_value("gp_status_2", 64'(gp_status_2), 64'(flags));
    @(posedge link_clk);
  endtask

  task automatic check_words(input int n0, input int n1);
    check_value("word count lane 0", 64'(words_seen[0] - word_base[0]), 64'(n0));
    check_value("word count lane 1", 64'(words_seen[1] - word_base[1]), 64'(n1));
  endtask

  task automatic begin_test(input string name);
    test_name    = name;
    test_err0    = errors;
    word_base[0] = words_seen[0];
    word_base[1] = words_seen[1];
    tests_run++;
  endtask

  task automatic end_test();
    if (errors == test_err0) begin
      $display("test %0d %s: ok", tests_run, test_name);
    end else begin
      tests_failed++;
      $display("test %0d %s: %0d errors", tests_run, test_name, errors - test_err0);
    end
  endtask

  initial begin : main
    int l;
    seed         = 32'h00053454;
    errors       = 0;
    checks       = 0;
    tests_run    = 0;
    tests_failed = 0;
    tag_seq      = 0;
    words_seen   = '{0, 0};
    rst_n      <= 1'b0;
    gp_control <= 32'(1) << rx_pkg::CTRL_ENABLE_BIT;
    trigger    <= 1'b0;
    long_cp    <= 1'b0;
    din_symbol <= '0;
    din_slot   <= '0;
    din_frame  <= '0;
    valid_in   <= '0;
    full_scale <= '0;
    for (l = 0; l < LANES; l++) begin
      data_in_i[l] <= '0;
      data_in_q[l] <= '0;
      enable_in[l] <= 2'b11;
    end
    repeat (16) @(posedge link_clk);
    rst_n <= 1'b1;
    wait_restart();

    begin_test("long cp on both lanes");
    send_trigger(1'b1);
    wait_drained("long cp symbol");
    check_words(WORDS_PER_SYM, WORDS_PER_SYM);
    end_test();

    begin_test("short cp and bypass");
    send_trigger(1'b0);
    wait_drained("short cp symbol");
    gp_control[rx_pkg::CTRL_BYPASS_CP_BIT] <= 1'b1;
    send_trigger(1'b1);
    wait_drained("bypass symbol");
    gp_control[rx_pkg::CTRL_BYPASS_CP_BIT] <= 1'b0;
    check_words(2 * WORDS_PER_SYM, 2 * WORDS_PER_SYM);
    end_test();

    begin_test("ignored trigger and disabled lane");
    send_trigger(1'b1);
    // second trigger lands in the middle of the symbol
    repeat (20) @(posedge link_clk);
    send_trigger(1'b0);
    wait_drained("symbol with a second trigger");
    repeat (40) @(posedge link_clk);
    check_words(WORDS_PER_SYM, WORDS_PER_SYM);
    enable_in[1] <= 2'b01;
    send_trigger(1'b0);
    wait_drained("symbol with lane 1 disabled");
    enable_in[1] <= 2'b11;
    check_words(2 * WORDS_PER_SYM, WORDS_PER_SYM);
    end_test();

    begin_test("saturation on lane 0");
    full_scale <= 2'b01;
    send_trigger(1'b1);
    wait_drained("full scale symbol");
    full_scale <= 2'b00;
    check_words(WORDS_PER_SYM, WORDS_PER_SYM);
    check_status(6, 5, 32'h0100_0000);
    end_test();

    begin_test("counters and restart");
    // six symbols on lane 0 and five on lane 1 since reset
    check_status(6, 5, 32'h0100_0000);
    gp_control[rx_pkg::CTRL_ENABLE_BIT] <= 1'b0;
    repeat (2) @(posedge link_clk);
    check_status(0, 0, 32'h0);
    gp_control[rx_pkg::CTRL_ENABLE_BIT] <= 1'b1;
    wait_restart();
    send_trigger(1'b0);
    wait_drained("symbol after restart");
    check_words(WORDS_PER_SYM, WORDS_PER_SYM);
    check_status(1, 1, 32'h0);
    end_test();

    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: design/harden_rx.sv
// status mapping assumes LANES = 2; enable_in bit 0 is the i enable and bit 1 the q enable of a lane
`timescale 1ns/100ps

module harden_rx #(
  parameter int LANES        = 2,
  parameter int FFT_SIZE     = 64,
  parameter int CP_LEN_LONG  = 11,
  parameter int CP_LEN_SHORT = 9
) (
  input  logic                      link_clk,
  input  logic                      rst_n,
  input  logic [31:0]               gp_control,
  output logic [31:0]               gp_status_0,
  output logic [31:0]               gp_status_1,
  output logic [31:0]               gp_status_2,
  input  logic                      trigger,
  input  logic                      long_cp,
  input  logic [3:0]                din_symbol,
  input  logic [7:0]                din_slot,
  input  logic [9:0]                din_frame,
  input  logic [15:0]               data_in_i [LANES],
  input  logic [15:0]               data_in_q [LANES],
  input  logic [LANES-1:0]          valid_in,
  input  logic [1:0]                enable_in [LANES],
  output logic [rx_pkg::WORD_W-1:0] dout_data [LANES],
  output logic [LANES-1:0]          dout_valid,
  output logic [LANES-1:0]          dout_sop,
  output logic [LANES-1:0]          dout_eop,
  output logic [3:0]                dout_symbol [LANES],
  output logic [7:0]                dout_slot [LANES],
  output logic [9:0]                dout_frame [LANES]
);

  rx_pkg::rx_cfg_t    cfg;
  rx_pkg::sym_start_t sym_start;
  rx_pkg::sym_tag_t   din_tag;
  logic               lane_rst_n;
  rx_pkg::rx_word_t   lane_word [LANES];
  logic [LANES-1:0]   lane_sat;
  rx_pkg::rx_word_t   dout [LANES];
  logic [31:0]        xfer_cnt [LANES];
  logic [LANES-1:0]   sat_ever;

  assign din_tag = '{symbol: din_symbol, slot: din_slot, frame: din_frame};

  rx_ctrl u_ctrl (
    .link_clk  (link_clk),
    .rst_n     (rst_n),
    .gp_control(gp_control),
    .trigger   (trigger),
    .long_cp   (long_cp),
    .tag       (din_tag),
    .cfg       (cfg),
    .sym_start (sym_start),
    .lane_rst_n(lane_rst_n)
  );

  genvar g;
  generate
    for (g = 0; g < LANES; g++) begin : g_lane
      rx_pkg::iq16_t lane_din;
      logic          lane_enable;

      assign lane_din    = '{re: data_in_i[g], im: data_in_q[g]};
      assign lane_enable = &enable_in[g];

      rx_lane #(
        .FFT_SIZE    (FFT_SIZE),
        .CP_LEN_LONG (CP_LEN_LONG),
        .CP_LEN_SHORT(CP_LEN_SHORT)
      ) u_lane (
        .link_clk   (link_clk),
        .rst_n      (lane_rst_n),
        .lane_enable(lane_enable),
        .bypass_cp  (cfg.bypass_cp),
        .sym_start  (sym_start),
        .din        (lane_din),
        .din_valid  (valid_in[g]),
        .word       (lane_word[g]),
        .sat        (lane_sat[g])
      );

      assign dout_data[g]   = dout[g].data;
      assign dout_valid[g]  = dout[g].valid;
      assign dout_sop[g]    = dout[g].sop;
      assign dout_eop[g]    = dout[g].eop;
      assign dout_symbol[g] = dout[g].tag.symbol;
      assign dout_slot[g]   = dout[g].tag.slot;
      assign dout_frame[g]  = dout[g].tag.frame;
    end
  endgenerate

  rx_status #(
    .LANES(LANES)
  ) u_status (
    .link_clk(link_clk),
    .rst_n   (lane_rst_n),
    .words   (lane_word),
    .sat     (lane_sat),
    .dout    (dout),
    .xfer_cnt(xfer_cnt),
    .sat_ever(sat_ever)
  );

  assign gp_status_0 = xfer_cnt[0];
  assign gp_status_1 = xfer_cnt[1];
  // sticky saturation in bits 25:24
  assign gp_status_2 = {{(8 - LANES){1'b0}}, sat_ever, 24'd0};

endmodule

// File: design/rx_status.sv
// output words are registered once with no back-pressure; counters and flags clear only on the lane reset
`timescale 1ns/100ps

module rx_status #(
  parameter int LANES = 2
) (
  input  logic             link_clk,
  input  logic             rst_n,
  input  rx_pkg::rx_word_t words [LANES],
  input  logic [LANES-1:0] sat,
  output rx_pkg::rx_word_t dout [LANES],
  output logic [31:0]      xfer_cnt [LANES],
  output logic [LANES-1:0] sat_ever
);

  genvar g;
  generate
    for (g = 0; g < LANES; g++) begin : g_lane
      logic                      valid_q;
      logic                      sop_q;
      logic                      eop_q;
      logic [rx_pkg::WORD_W-1:0] data_q;
      rx_pkg::sym_tag_t          tag_q;
      logic [31:0]               cnt_q;
      logic                      sat_q;

      always_ff @(posedge link_clk or negedge rst_n) begin
        if (!rst_n) begin
          valid_q <= 1'b0;
          sop_q   <= 1'b0;
          eop_q   <= 1'b0;
          cnt_q   <= '0;
          sat_q   <= 1'b0;
        end else begin
          valid_q <= words[g].valid;
          sop_q   <= words[g].sop;
          eop_q   <= words[g].eop;
          // one count per completed symbol
          if (words[g].valid && words[g].eop) begin
            cnt_q <= cnt_q + 1'b1;
          end
          if (sat[g]) begin
            sat_q <= 1'b1;
          end
        end
      end

      always_ff @(posedge link_clk) begin
        data_q <= words[g].data;
        tag_q  <= words[g].tag;
      end

      assign dout[g] = '{
        data:  data_q,
        valid: valid_q,
        sop:   sop_q,
        eop:   eop_q,
        tag:   tag_q
      };
      assign xfer_cnt[g] = cnt_q;
      assign sat_ever[g] = sat_q;

      eop_with_valid: assert property (@(posedge link_clk) disable iff (!rst_n)
        words[g].eop |-> words[g].valid);
    end
  endgenerate

endmodule

// File: design/rx_lane.sv
// FFT_SIZE must be a multiple of SAMPLES_PER_WORD so that eop always lands on the last sample of a word
`timescale 1ns/100ps

module rx_lane #(
  parameter int FFT_SIZE     = 64,
  parameter int CP_LEN_LONG  = 11,
  parameter int CP_LEN_SHORT = 9
) (
  input  logic               link_clk,
  input  logic               rst_n,
  input  logic               lane_enable,
  input  logic               bypass_cp,
  input  rx_pkg::sym_start_t sym_start,
  input  rx_pkg::iq16_t      din,
  input  logic               din_valid,
  output rx_pkg::rx_word_t   word,
  output logic               sat
);

  localparam int IDX_W  = $clog2(rx_pkg::SAMPLES_PER_WORD);
  localparam int PAIR_W = 2 * rx_pkg::COMP_W;
  localparam int HOLD_W = rx_pkg::WORD_W - PAIR_W;

  rx_pkg::iq16_t           rm_dout;
  logic                    rm_valid;
  logic                    rm_sop;
  logic                    rm_eop;
  rx_pkg::sym_tag_t        rm_tag;
  rx_pkg::iq8_t            c_dout;
  logic                    c_valid;
  logic                    c_sop;
  logic                    c_eop;
  logic [IDX_W-1:0]        idx;
  logic [IDX_W-1:0]        cur_idx;
  logic                    last_sample;
  logic [HOLD_W-1:0]       hold;
  logic                    sop_seen;
  rx_pkg::sym_tag_t        sym_tag;
  logic [rx_pkg::WORD_W-1:0] word_data;
  logic                    word_valid;
  logic                    word_sop;
  logic                    word_eop;
  rx_pkg::sym_tag_t        word_tag;

  cp_remover #(
    .FFT_SIZE    (FFT_SIZE),
    .CP_LEN_LONG (CP_LEN_LONG),
    .CP_LEN_SHORT(CP_LEN_SHORT)
  ) u_cp_remover (
    .link_clk   (link_clk),
    .rst_n      (rst_n),
    .lane_enable(lane_enable),
    .bypass_cp  (bypass_cp),
    .sym_start  (sym_start),
    .din        (din),
    .din_valid  (din_valid),
    .dout       (rm_dout),
    .dout_valid (rm_valid),
    .dout_sop   (rm_sop),
    .dout_eop   (rm_eop),
    .tag        (rm_tag)
  );

  sample_compressor u_compressor (
    .link_clk  (link_clk),
    .rst_n     (rst_n),
    .din       (rm_dout),
    .din_valid (rm_valid),
    .din_sop   (rm_sop),
    .din_eop   (rm_eop),
    .dout      (c_dout),
    .dout_valid(c_valid),
    .dout_sop  (c_sop),
    .dout_eop  (c_eop),
    .sat       (sat)
  );

  // sop realigns the packer
  assign cur_idx     = c_sop ? '0 : idx;
  assign last_sample = c_valid && (cur_idx == IDX_W'(rx_pkg::SAMPLES_PER_WORD - 1));

  always_ff @(posedge link_clk or negedge rst_n) begin
    if (!rst_n) begin
      idx        <= '0;
      sop_seen   <= 1'b0;
      word_valid <= 1'b0;
      word_sop   <= 1'b0;
      word_eop   <= 1'b0;
    end else begin
      word_valid <= last_sample;
      word_sop   <= last_sample && (sop_seen || c_sop);
      word_eop   <= last_sample && c_eop;
      if (c_valid) begin
        idx <= cur_idx + 1'b1;
        if (last_sample) begin
          sop_seen <= 1'b0;
        end else if (c_sop) begin
          sop_seen <= 1'b1;
        end
      end
    end
  end

  // sample 0 shifts up into the top byte pair
  always_ff @(posedge link_clk) begin
    if (c_valid) begin
      hold <= {hold[HOLD_W-PAIR_W-1:0], c_dout.re, c_dout.im};
    end
    if (last_sample) begin
      word_data <= {hold, c_dout.re, c_dout.im};
      word_tag  <= sym_tag;
    end
    // held apart from the remover tag so a new trigger cannot retag words in flight
    if (rm_valid && rm_sop) begin
      sym_tag <= rm_tag;
    end
  end

  assign word = '{
    data:  word_data,
    valid: word_valid,
    sop:   word_sop,
    eop:   word_eop,
    tag:   word_tag
  };

endmodule

// File: design/sample_compressor.sv
// round half up then saturate each component from 16 to 8 bits; only the positive rail can clip in practice
`timescale 1ns/100ps

module sample_compressor (
  input  logic          link_clk,
  input  logic          rst_n,
  input  rx_pkg::iq16_t din,
  input  logic          din_valid,
  input  logic          din_sop,
  input  logic          din_eop,
  output rx_pkg::iq8_t  dout,
  output logic          dout_valid,
  output logic          dout_sop,
  output logic          dout_eop,
  output logic          sat
);

  localparam int SW = rx_pkg::SAMPLE_W;
  localparam int CW = rx_pkg::COMP_W;
  localparam logic [CW-1:0] MAX_V = {1'b0, {(CW - 1){1'b1}}};
  // smallest input that rounds past the positive rail
  localparam int CLIP_IN = (1 << (SW - 1)) - (1 << (SW - CW - 1));

  // msb of the result flags a clipped value
  function automatic logic [CW:0] compress(input logic signed [SW-1:0] x);
    logic signed [SW:0] rounded;
    logic signed [CW:0] shifted;
    rounded = {x[SW-1], x} + (SW + 1)'(1 << (SW - CW - 1));
    shifted = rounded[SW:SW-CW];
    if (shifted[CW] != shifted[CW-1]) begin
      compress = {1'b1, shifted[CW], {(CW - 1){~shifted[CW]}}};
    end else begin
      compress = {1'b0, shifted[CW-1:0]};
    end
  endfunction

  logic [CW:0] re_c;
  logic [CW:0] im_c;

  assign re_c = compress(din.re);
  assign im_c = compress(din.im);

  always_ff @(posedge link_clk or negedge rst_n) begin
    if (!rst_n) begin
      dout_valid <= 1'b0;
      dout_sop   <= 1'b0;
      dout_eop   <= 1'b0;
      sat        <= 1'b0;
    end else begin
      dout_valid <= din_valid;
      dout_sop   <= din_valid && din_sop;
      dout_eop   <= din_valid && din_eop;
      sat        <= din_valid && (re_c[CW] || im_c[CW]);
    end
  end

  always_ff @(posedge link_clk) begin
    if (din_valid) begin
      dout <= '{re: re_c[CW-1:0], im: im_c[CW-1:0]};
    end
  end

  sat_at_rail: assert property (@(posedge link_clk) disable iff (!rst_n)
    sat |-> ((dout.re == MAX_V) && $past(din.re >= CLIP_IN)) ||
            ((dout.im == MAX_V) && $past(din.im >= CLIP_IN)));

endmodule

// File: design/cp_remover.sv
// one symbol per accepted trigger; triggers while busy are dropped and the sample on the accepting edge is not counted
`timescale 1ns/100ps

module cp_remover #(
  parameter int FFT_SIZE     = 64,
  parameter int CP_LEN_LONG  = 11,
  parameter int CP_LEN_SHORT = 9
) (
  input  logic               link_clk,
  input  logic               rst_n,
  input  logic               lane_enable,
  input  logic               bypass_cp,
  input  rx_pkg::sym_start_t sym_start,
  input  rx_pkg::iq16_t      din,
  input  logic               din_valid,
  output rx_pkg::iq16_t      dout,
  output logic               dout_valid,
  output logic               dout_sop,
  output logic               dout_eop,
  output rx_pkg::sym_tag_t   tag
);

  localparam int CNT_W = $clog2(FFT_SIZE + CP_LEN_LONG + CP_LEN_SHORT);

  rx_pkg::cp_state_e state;
  logic [CNT_W-1:0]  cnt;
  logic [CNT_W-1:0]  cp_len;
  logic              start_ok;
  logic              pass_fire;

  assign start_ok  = (state == rx_pkg::idle) && lane_enable && sym_start.trigger;
  assign pass_fire = (state == rx_pkg::pass_sym) && din_valid;

  // bypass means a zero length prefix
  assign cp_len = bypass_cp        ? '0 :
                  sym_start.long_cp ? CNT_W'(CP_LEN_LONG) : CNT_W'(CP_LEN_SHORT);

  // cnt counts down through the prefix, then up through the symbol
  always_ff @(posedge link_clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= rx_pkg::idle;
      cnt   <= '0;
    end else begin
      case (state)
        rx_pkg::idle: begin
          if (start_ok) begin
            if (cp_len == '0) begin
              state <= rx_pkg::pass_sym;
              cnt   <= '0;
            end else begin
              state <= rx_pkg::skip_cp;
              cnt   <= cp_len - 1'b1;
            end
          end
        end
        rx_pkg::skip_cp: begin
          if (din_valid) begin
            if (cnt == '0) begin
              state <= rx_pkg::pass_sym;
            end else begin
              cnt <= cnt - 1'b1;
            end
          end
        end
        rx_pkg::pass_sym: begin
          if (din_valid) begin
            if (cnt == CNT_W'(FFT_SIZE - 1)) begin
              state <= rx_pkg::idle;
              cnt   <= '0;
            end else begin
              cnt <= cnt + 1'b1;
            end
          end
        end
        default: begin
          state <= rx_pkg::idle;
        end
      endcase
    end
  end

  always_ff @(posedge link_clk or negedge rst_n) begin
    if (!rst_n) begin
      dout_valid <= 1'b0;
      dout_sop   <= 1'b0;
      dout_eop   <= 1'b0;
    end else begin
      dout_valid <= pass_fire;
      dout_sop   <= pass_fire && (cnt == '0);
      dout_eop   <= pass_fire && (cnt == CNT_W'(FFT_SIZE - 1));
    end
  end

  always_ff @(posedge link_clk) begin
    if (pass_fire) begin
      dout <= din;
    end
    // tag belongs to the symbol being framed
    if (start_ok) begin
      tag <= sym_start.tag;
    end
  end

  // eop marks exactly the edge where the symbol leaves pass_sym
  eop_in_symbol: assert property (@(posedge link_clk) disable iff (!rst_n)
    dout_eop == $fell(state == rx_pkg::pass_sym));

endmodule

// File: design/rx_ctrl.sv
// gpio decode is combinational; lane reset drops asynchronously on rst_n or enable low and restarts after RST_STAGES cycles
`timescale 1ns/100ps

module rx_ctrl (
  input  logic                 link_clk,
  input  logic                 rst_n,
  input  logic [31:0]          gp_control,
  input  logic                 trigger,
  input  logic                 long_cp,
  input  rx_pkg::sym_tag_t     tag,
  output rx_pkg::rx_cfg_t      cfg,
  output rx_pkg::sym_start_t   sym_start,
  output logic                 lane_rst_n
);

  localparam int RCNT_W = $clog2(rx_pkg::RST_STAGES + 1);

  logic              restart_n;
  logic [RCNT_W-1:0] rst_cnt;
  logic              trig_q;
  logic              long_cp_q;
  rx_pkg::sym_tag_t  tag_q;

  assign cfg = '{
    enable:    gp_control[rx_pkg::CTRL_ENABLE_BIT],
    bypass_cp: gp_control[rx_pkg::CTRL_BYPASS_CP_BIT]
  };

  // clearing the enable bit restarts the whole data path
  assign restart_n = rst_n & cfg.enable;

  always_ff @(posedge link_clk or negedge restart_n) begin
    if (!restart_n) begin
      rst_cnt <= '0;
    end else if (rst_cnt != RCNT_W'(rx_pkg::RST_STAGES)) begin
      rst_cnt <= rst_cnt + 1'b1;
    end
  end

  assign lane_rst_n = (rst_cnt == RCNT_W'(rx_pkg::RST_STAGES));

  // trigger strobe
  always_ff @(posedge link_clk or negedge rst_n) begin
    if (!rst_n) begin
      trig_q <= 1'b0;
    end else begin
      trig_q <= trigger;
    end
  end

  // cp selection and tag ride along with the strobe
  always_ff @(posedge link_clk) begin
    long_cp_q <= long_cp;
    tag_q     <= tag;
  end

  assign sym_start = '{trigger: trig_q, long_cp: long_cp_q, tag: tag_q};

endmodule

// File: design/rx_pkg.sv
// shared types for the two-lane receiver; sample widths fixed at 16 in, 8 out, and SAMPLES_PER_WORD must be a power of two
package rx_pkg;

  localparam int SAMPLE_W = 16;
  localparam int COMP_W   = 8;
  localparam int WORD_W   = 64;

  // gpio control bit positions
  localparam int CTRL_ENABLE_BIT    = 15;
  localparam int CTRL_BYPASS_CP_BIT = 9;

  localparam int SAMPLES_PER_WORD = 4;
  localparam int RST_STAGES       = 8;

  // converter sample
  typedef struct packed {
    logic signed [SAMPLE_W-1:0] re;
    logic signed [SAMPLE_W-1:0] im;
  } iq16_t;

  // compressed sample
  typedef struct packed {
    logic signed [COMP_W-1:0] re;
    logic signed [COMP_W-1:0] im;
  } iq8_t;

  typedef struct packed {
    logic [3:0] symbol;
    logic [7:0] slot;
    logic [9:0] frame;
  } sym_tag_t;

  // registered start command, shared by all lanes
  typedef struct packed {
    logic     trigger;
    logic     long_cp;
    sym_tag_t tag;
  } sym_start_t;

  typedef struct packed {
    logic enable;
    logic bypass_cp;
  } rx_cfg_t;

  typedef struct packed {
    logic [WORD_W-1:0] data;
    logic              valid;
    logic              sop;
    logic              eop;
    sym_tag_t          tag;
  } rx_word_t;

  typedef enum logic [1:0] {
    idle,
    skip_cp,
    pass_sym
  } cp_state_e;

endpackage
